// File: common/ekf_pkg.sv
package ekf_pkg;

  // Q1.12.19 fixed point
  localparam int FRAC_W = 19;

  typedef logic signed [31:0] fx_t;

  localparam fx_t FX_ONE  = 32'sh0008_0000;  // 1.0, identity entry
  localparam fx_t Q_NOISE = FX_ONE;          // measurement noise on the S diagonal

  // B-cache write modes, codes not listed here act as idle
  typedef enum logic [3:0] {
    IDLE   = 4'b0000,
    WR_INV = 4'b1010,
    NL_PRD = 4'b1100,
    NL_NEW = 4'b1110,
    NL_UPD = 4'b1111
  } bca_sel_e;

  typedef struct packed {
    fx_t fxi_13;
    fx_t fxi_23;
  } pred_jac_t;

  typedef struct packed {
    fx_t gxi_13;
    fx_t gxi_23;
    fx_t gz_11;
    fx_t gz_12;
    fx_t gz_21;
    fx_t gz_22;
  } new_lm_t;

  typedef struct packed {
    fx_t hxi_11;
    fx_t hxi_12;
    fx_t hxi_21;
    fx_t hxi_22;
    fx_t hz_11;
    fx_t hz_12;
    fx_t hz_21;
    fx_t hz_22;
    fx_t vt_1;
    fx_t vt_2;
  } upd_jac_t;

  // raw innovation covariance, Q not yet added
  typedef struct packed {
    fx_t s11;
    fx_t s21;
    fx_t s22;
  } s_mat_t;

  typedef struct packed {
    fx_t inv11;
    fx_t inv12;
    fx_t inv22;
  } s_inv_t;

endpackage

// File: s_inv/fx_div.sv
module fx_div #(
  parameter int DIV_ITER = 51
) (
  input  logic         clk,
  input  logic         sys_rst,
  input  logic         div_start,
  input  ekf_pkg::fx_t dividend,
  input  ekf_pkg::fx_t divisor,
  output logic         div_valid,
  output ekf_pkg::fx_t quotient
);

  localparam int CNT_W = $clog2(DIV_ITER + 1);
  localparam logic [DIV_ITER-1:0] MAG_MAX = DIV_ITER'(32'h7fff_ffff);

  logic                busy;
  logic [CNT_W-1:0]    cnt;
  logic [31:0]         rem;
  logic [DIV_ITER-1:0] acc;  // dividend bits leave at the top, quotient bits enter below
  logic [31:0]         dvsr_mag;
  logic                neg;
  logic                zero_div;
  logic [31:0]         dvnd_mag_in;
  logic [31:0]         dvsr_mag_in;
  logic [32:0]         rem_sh;
  logic [33:0]         diff;
  logic [31:0]         rem_nxt;
  logic [DIV_ITER-1:0] acc_nxt;
  logic [30:0]         q_mag;
  ekf_pkg::fx_t        q_pos;

  assign dvnd_mag_in = dividend[31] ? -dividend : dividend;
  assign dvsr_mag_in = divisor[31] ? -divisor : divisor;

  // one restoring step
  assign rem_sh  = {rem, acc[DIV_ITER-1]};
  assign diff    = {1'b0, rem_sh} - {2'b00, dvsr_mag};
  assign rem_nxt = diff[33] ? rem_sh[31:0] : diff[31:0];
  assign acc_nxt = {acc[DIV_ITER-2:0], ~diff[33]};

  assign q_mag = (zero_div || acc_nxt > MAG_MAX) ? '1 : acc_nxt[30:0];  // saturate
  assign q_pos = {1'b0, q_mag};

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      busy      <= 1'b0;
      cnt       <= '0;
      div_valid <= 1'b0;
    end else begin
      div_valid <= 1'b0;
      if (div_start && !busy) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(DIV_ITER);
      end else if (busy) begin
        cnt <= cnt - 1'b1;
        if (cnt == CNT_W'(1)) begin
          busy      <= 1'b0;
          div_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (div_start && !busy) begin
      rem      <= '0;
      acc      <= DIV_ITER'({dvnd_mag_in, {ekf_pkg::FRAC_W{1'b0}}});
      dvsr_mag <= dvsr_mag_in;
      zero_div <= (divisor == '0);
      neg      <= (divisor == '0) ? dividend[31] : dividend[31] ^ divisor[31];
    end else if (busy) begin
      rem <= rem_nxt;
      acc <= acc_nxt;
      if (cnt == CNT_W'(1))
        quotient <= neg ? -q_pos : q_pos;
    end
  end

  // the inverse FSM waits for div_valid before the next start
  a_no_restart: assert property (@(posedge clk) disable iff (sys_rst) busy |-> !div_start);

endmodule

// File: s_inv/s_inv_core.sv
module s_inv_core #(
  parameter int DIV_ITER = 51
) (
  input  logic              clk,
  input  logic              sys_rst,
  input  ekf_pkg::s_mat_t   s_mat,
  input  logic              inv_start,
  output logic              inv_done,
  output ekf_pkg::s_inv_t   s_inv
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_MUL1,
    ST_MUL2,
    ST_DIV11,
    ST_DIV12,
    ST_DIV22
  } state_e;

  state_e              state;
  ekf_pkg::fx_t        s11;
  ekf_pkg::fx_t        s21;
  ekf_pkg::fx_t        s22;
  ekf_pkg::fx_t        s11_s22;
  ekf_pkg::fx_t        det;
  ekf_pkg::fx_t        mul_a;
  ekf_pkg::fx_t        mul_b;
  ekf_pkg::fx_t        mul_c;
  logic signed [63:0]  mul_full;
  logic                div_start;
  logic                div_valid;
  ekf_pkg::fx_t        dividend;
  ekf_pkg::fx_t        quotient;

  // single shared multiplier, S11*S22 first then S21*S21
  assign mul_a    = (state == ST_MUL1) ? s11 : s21;
  assign mul_b    = (state == ST_MUL1) ? s22 : s21;
  assign mul_full = 64'(mul_a) * 64'(mul_b);
  assign mul_c    = {mul_full[63], mul_full[ekf_pkg::FRAC_W+30:ekf_pkg::FRAC_W]};

  always_comb begin
    case (state)
      ST_DIV12: dividend = -s21;
      ST_DIV22: dividend = s11;
      default:  dividend = s22;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state     <= ST_IDLE;
      div_start <= 1'b0;
      inv_done  <= 1'b0;
    end else begin
      div_start <= 1'b0;
      inv_done  <= 1'b0;
      case (state)
        ST_IDLE:
          if (inv_start) state <= ST_MUL1;  // starts while busy are dropped
        ST_MUL1:
          state <= ST_MUL2;
        ST_MUL2: begin
          state     <= ST_DIV11;
          div_start <= 1'b1;
        end
        ST_DIV11:
          if (div_valid) begin
            state     <= ST_DIV12;
            div_start <= 1'b1;
          end
        ST_DIV12:
          if (div_valid) begin
            state     <= ST_DIV22;
            div_start <= 1'b1;
          end
        ST_DIV22:
          if (div_valid) begin
            state    <= ST_IDLE;
            inv_done <= 1'b1;
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && inv_start) begin
      s11 <= s_mat.s11 + ekf_pkg::Q_NOISE;
      s21 <= s_mat.s21;
      s22 <= s_mat.s22 + ekf_pkg::Q_NOISE;
    end
    if (state == ST_MUL1)
      s11_s22 <= mul_c;
    if (state == ST_MUL2)
      det <= s11_s22 - mul_c;
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      s_inv <= '0;
    end else if (div_valid) begin
      case (state)
        ST_DIV11: s_inv.inv11 <= quotient;
        ST_DIV12: s_inv.inv12 <= quotient;
        ST_DIV22: s_inv.inv22 <= quotient;
        default:  ;
      endcase
    end
  end

  fx_div #(
    .DIV_ITER (DIV_ITER)
  ) u_fx_div (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .div_start (div_start),
    .dividend  (dividend),
    .divisor   (det),
    .div_valid (div_valid),
    .quotient  (quotient)
  );

  a_done_pulse: assert property (@(posedge clk) disable iff (sys_rst) inv_done |=> !inv_done);

endmodule

// File: hdl/bcache_din_map.sv
module bcache_din_map #(
  parameter int LANES = 4,
  parameter int SEQ_W = 5
) (
  input  logic                     clk,
  input  logic                     sys_rst,
  input  ekf_pkg::bca_sel_e        bca_sel,
  input  logic [SEQ_W-1:0]         seq_cnt,
  input  ekf_pkg::pred_jac_t       pred_jac,
  input  ekf_pkg::new_lm_t         new_lm,
  input  ekf_pkg::upd_jac_t        upd_jac,
  input  ekf_pkg::s_inv_t          s_inv,
  output ekf_pkg::fx_t [LANES-1:0] b_cache_din
);

  ekf_pkg::fx_t [LANES-1:0] row;

  if (LANES < 3) begin : g_lane_chk
    $error("bcache_din_map needs at least 3 lanes");
  end

  // unlisted lanes and seq values stay zero
  always_comb begin
    row = '0;
    case (bca_sel)
      ekf_pkg::NL_PRD:
        case (seq_cnt)
          SEQ_W'(1): row[0] = ekf_pkg::FX_ONE;
          SEQ_W'(3): begin
            row[0] = pred_jac.fxi_13;
            row[1] = ekf_pkg::FX_ONE;
          end
          SEQ_W'(4): row[1] = pred_jac.fxi_23;
          SEQ_W'(5): row[2] = ekf_pkg::FX_ONE;
          default: ;
        endcase
      ekf_pkg::NL_NEW:
        case (seq_cnt)
          SEQ_W'(1): row[0] = ekf_pkg::FX_ONE;
          SEQ_W'(3): begin
            row[0] = new_lm.gxi_13;
            row[1] = ekf_pkg::FX_ONE;
          end
          SEQ_W'(4): begin
            row[0] = new_lm.gz_11;
            row[1] = new_lm.gxi_23;
          end
          SEQ_W'(5): begin
            row[0] = new_lm.gz_12;
            row[1] = new_lm.gz_21;
          end
          SEQ_W'(6): row[1] = new_lm.gz_22;
          default: ;
        endcase
      ekf_pkg::NL_UPD:
        case (seq_cnt)
          SEQ_W'(1): row[0] = upd_jac.hxi_11;
          SEQ_W'(2): begin
            row[0] = upd_jac.hxi_12;
            row[1] = upd_jac.hxi_21;
          end
          SEQ_W'(3): row[1] = upd_jac.hxi_22;
          SEQ_W'(4): begin
            row[0] = upd_jac.hz_11;
            row[1] = -ekf_pkg::FX_ONE;  // -I
          end
          SEQ_W'(5): begin
            row[0] = upd_jac.hz_12;
            row[1] = upd_jac.hz_21;
          end
          SEQ_W'(6): begin
            row[0] = upd_jac.vt_1;
            row[1] = upd_jac.hz_22;
          end
          SEQ_W'(7): row[0] = upd_jac.vt_2;
          default: ;
        endcase
      ekf_pkg::WR_INV:
        case (seq_cnt)
          SEQ_W'(1): row[0] = s_inv.inv11;
          SEQ_W'(2): begin
            row[0] = s_inv.inv12;  // symmetric, same value twice
            row[1] = s_inv.inv12;
          end
          SEQ_W'(3): row[1] = s_inv.inv22;
          default: ;
        endcase
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst)
      b_cache_din <= '0;
    else
      b_cache_din <= row;
  end

  // sequencer must drive a defined mode once out of reset
  a_sel_known: assert property (@(posedge clk) disable iff (sys_rst) !$isunknown(bca_sel));

endmodule

// File: hdl/bcache_din_top.sv
module bcache_din_top #(
  parameter int LANES    = 4,
  parameter int SEQ_W    = 5,
  parameter int DIV_ITER = 51
) (
  input  logic                     clk,
  input  logic                     sys_rst,
  input  ekf_pkg::bca_sel_e        bca_sel,
  input  logic [SEQ_W-1:0]         seq_cnt,
  input  ekf_pkg::pred_jac_t       pred_jac,
  input  ekf_pkg::new_lm_t         new_lm,
  input  ekf_pkg::upd_jac_t        upd_jac,
  input  ekf_pkg::s_mat_t          s_mat,
  input  logic                     inv_start,
  output logic                     inv_done,
  output ekf_pkg::fx_t [LANES-1:0] b_cache_din
);

  ekf_pkg::s_inv_t s_inv;  // held between inv_done and the next start

  s_inv_core #(
    .DIV_ITER (DIV_ITER)
  ) u_s_inv_core (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .s_mat     (s_mat),
    .inv_start (inv_start),
    .inv_done  (inv_done),
    .s_inv     (s_inv)
  );

  bcache_din_map #(
    .LANES (LANES),
    .SEQ_W (SEQ_W)
  ) u_bcache_din_map (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .bca_sel     (bca_sel),
    .seq_cnt     (seq_cnt),
    .pred_jac    (pred_jac),
    .new_lm      (new_lm),
    .upd_jac     (upd_jac),
    .s_inv       (s_inv),
    .b_cache_din (b_cache_din)
  );

endmodule

// File: verification/tb_bcache_din_vectors.svh
`ifndef TB_BCACHE_DIN_VECTORS_SVH
`define TB_BCACHE_DIN_VECTORS_SVH

// columns: write mode, sequence count, index into exp_rows
typedef struct packed {
  ekf_pkg::bca_sel_e sel;
  logic [4:0]        seq;
  logic [4:0]        idx;
} vec_t;

localparam ekf_pkg::bca_sel_e M_PRD    = ekf_pkg::NL_PRD;
localparam ekf_pkg::bca_sel_e M_NEW    = ekf_pkg::NL_NEW;
localparam ekf_pkg::bca_sel_e M_UPD    = ekf_pkg::NL_UPD;
localparam ekf_pkg::bca_sel_e M_INV    = ekf_pkg::WR_INV;
localparam ekf_pkg::bca_sel_e M_IDLE   = ekf_pkg::IDLE;
localparam ekf_pkg::bca_sel_e M_UNUSED = ekf_pkg::bca_sel_e'(4'b0101);

localparam int N_VEC         = 35;
localparam int VEC_MAP_LAST  = 29;
localparam int VEC_INV_FIRST = 30;

localparam vec_t VEC_TAB [N_VEC] = '{
  // NL_PRD, seq 0 to 7
  '{M_PRD, 5'd0, 5'd0}, '{M_PRD, 5'd1, 5'd1}, '{M_PRD, 5'd2, 5'd0}, '{M_PRD, 5'd3, 5'd2},
  '{M_PRD, 5'd4, 5'd3}, '{M_PRD, 5'd5, 5'd4}, '{M_PRD, 5'd6, 5'd0}, '{M_PRD, 5'd7, 5'd0},
  // NL_NEW, seq 0 to 8
  '{M_NEW, 5'd0, 5'd0}, '{M_NEW, 5'd1, 5'd1}, '{M_NEW, 5'd2, 5'd0}, '{M_NEW, 5'd3, 5'd5},
  '{M_NEW, 5'd4, 5'd6}, '{M_NEW, 5'd5, 5'd7}, '{M_NEW, 5'd6, 5'd8}, '{M_NEW, 5'd7, 5'd0},
  '{M_NEW, 5'd8, 5'd0},
  // NL_UPD, seq 0 to 8
  '{M_UPD, 5'd0, 5'd0}, '{M_UPD, 5'd1, 5'd9}, '{M_UPD, 5'd2, 5'd10}, '{M_UPD, 5'd3, 5'd11},
  '{M_UPD, 5'd4, 5'd12}, '{M_UPD, 5'd5, 5'd13}, '{M_UPD, 5'd6, 5'd14},
  '{M_UPD, 5'd7, 5'd15}, '{M_UPD, 5'd8, 5'd0},
  // idle and a code with no meaning
  '{M_IDLE, 5'd1, 5'd0}, '{M_IDLE, 5'd5, 5'd0},
  '{M_UNUSED, 5'd1, 5'd0}, '{M_UNUSED, 5'd3, 5'd0},
  // WR_INV, seq 0 to 4
  '{M_INV, 5'd0, 5'd0}, '{M_INV, 5'd1, 5'd16}, '{M_INV, 5'd2, 5'd17},
  '{M_INV, 5'd3, 5'd18}, '{M_INV, 5'd4, 5'd0}
};

// Q1.12.19 product, arithmetic shift then sign plus 31 low bits
function automatic ekf_pkg::fx_t ref_mul(input ekf_pkg::fx_t a, input ekf_pkg::fx_t b);
  longint p;
  longint sh;
  p  = longint'(a) * longint'(b);
  sh = p >>> ekf_pkg::FRAC_W;
  return {p[63], sh[30:0]};
endfunction

// truncating divide on magnitudes, saturates on zero divisor or overflow
function automatic ekf_pkg::fx_t ref_div(input ekf_pkg::fx_t n, input ekf_pkg::fx_t d);
  longint       num;
  longint       den;
  longint       q;
  logic         neg;
  ekf_pkg::fx_t mag;
  num = (n < 0) ? -longint'(n) : longint'(n);
  den = (d < 0) ? -longint'(d) : longint'(d);
  if (den == 0) begin
    q   = 64'h7fff_ffff;
    neg = (n < 0);
  end else begin
    q   = (num << ekf_pkg::FRAC_W) / den;
    neg = (n < 0) != (d < 0);
    if (q > 64'h7fff_ffff)
      q = 64'h7fff_ffff;
  end
  mag = q[31:0];
  return neg ? -mag : mag;
endfunction

// symmetric 2x2 inverse with Q on the diagonal
function automatic ekf_pkg::s_inv_t ref_inv(input ekf_pkg::s_mat_t s);
  ekf_pkg::fx_t    s11;
  ekf_pkg::fx_t    s21;
  ekf_pkg::fx_t    s22;
  ekf_pkg::fx_t    det;
  ekf_pkg::s_inv_t r;
  s11     = s.s11 + ekf_pkg::Q_NOISE;
  s21     = s.s21;
  s22     = s.s22 + ekf_pkg::Q_NOISE;
  det     = ref_mul(s11, s22) - ref_mul(s21, s21);
  r.inv11 = ref_div(s22, det);
  r.inv12 = ref_div(-s21, det);
  r.inv22 = ref_div(s11, det);
  return r;
endfunction

// expected rows from the driven Jacobians and the reference inverse
task automatic build_rows();
  exp_rows        = '{default: '0};
  exp_rows[1][0]  = ekf_pkg::FX_ONE;
  exp_rows[2][0]  = pred_jac.fxi_13;
  exp_rows[2][1]  = ekf_pkg::FX_ONE;
  exp_rows[3][1]  = pred_jac.fxi_23;
  exp_rows[4][2]  = ekf_pkg::FX_ONE;
  exp_rows[5][0]  = new_lm.gxi_13;
  exp_rows[5][1]  = ekf_pkg::FX_ONE;
  exp_rows[6][0]  = new_lm.gz_11;
  exp_rows[6][1]  = new_lm.gxi_23;
  exp_rows[7][0]  = new_lm.gz_12;
  exp_rows[7][1]  = new_lm.gz_21;
  exp_rows[8][1]  = new_lm.gz_22;
  exp_rows[9][0]  = upd_jac.hxi_11;
  exp_rows[10][0] = upd_jac.hxi_12;
  exp_rows[10][1] = upd_jac.hxi_21;
  exp_rows[11][1] = upd_jac.hxi_22;
  exp_rows[12][0] = upd_jac.hz_11;
  exp_rows[12][1] = -ekf_pkg::FX_ONE;
  exp_rows[13][0] = upd_jac.hz_12;
  exp_rows[13][1] = upd_jac.hz_21;
  exp_rows[14][0] = upd_jac.vt_1;
  exp_rows[14][1] = upd_jac.hz_22;
  exp_rows[15][0] = upd_jac.vt_2;
  exp_rows[16][0] = inv_exp.inv11;
  exp_rows[17][0] = inv_exp.inv12;
  exp_rows[17][1] = inv_exp.inv12;
  exp_rows[18][1] = inv_exp.inv22;
endtask

`endif

// File: verification/tb_bcache_din.sv
module tb_bcache_din;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LANES      = 4;
  localparam int SEQ_W      = 5;
  localparam int DIV_ITER   = 51;
  localparam int DONE_LIMIT = 4 * (DIV_ITER + 8);  // three divisions plus slack

  logic                     clk;
  logic                     sys_rst;
  ekf_pkg::bca_sel_e        bca_sel;
  logic [SEQ_W-1:0]         seq_cnt;
  ekf_pkg::pred_jac_t       pred_jac;
  ekf_pkg::new_lm_t         new_lm;
  ekf_pkg::upd_jac_t        upd_jac;
  ekf_pkg::s_mat_t          s_mat;
  logic                     inv_start;
  logic                     inv_done;
  ekf_pkg::fx_t [LANES-1:0] b_cache_din;

  integer                   seed;
  ekf_pkg::fx_t [LANES-1:0] exp_rows [19];
  ekf_pkg::s_inv_t          inv_exp;
  ekf_pkg::s_mat_t          s_a;
  ekf_pkg::s_mat_t          s_b;
  ekf_pkg::s_mat_t          s_c;

  `include "tb_bcache_din_vectors.svh"

  bcache_din_top #(
    .LANES    (LANES),
    .SEQ_W    (SEQ_W),
    .DIV_ITER (DIV_ITER)
  ) DUT (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .bca_sel     (bca_sel),
    .seq_cnt     (seq_cnt),
    .pred_jac    (pred_jac),
    .new_lm      (new_lm),
    .upd_jac     (upd_jac),
    .s_mat       (s_mat),
    .inv_start   (inv_start),
    .inv_done    (inv_done),
    .b_cache_din (b_cache_din)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_row(input ekf_pkg::fx_t [LANES-1:0] got,
                           input ekf_pkg::fx_t [LANES-1:0] exp, input string what);
    if (got !== exp)
      report_fail($sformatf("MISMATCH at %0t: %s row %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_inv(input ekf_pkg::s_inv_t got, input ekf_pkg::s_inv_t exp,
                           input string what);
    if (got !== exp)
      report_fail($sformatf("MISMATCH at %0t: %s inverse %h/%h/%h expected %h/%h/%h",
                            $time, what, got.inv11, got.inv12, got.inv22,
                            exp.inv11, exp.inv12, exp.inv22));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_fail($sformatf("MISMATCH at %0t: %s is %b expected %b", $time, what, got, exp));
  endtask

  // magnitude below 2^21 so products stay in range
  function automatic ekf_pkg::fx_t rand_fx();
    ekf_pkg::fx_t r;
    r = $random(seed);
    return r >>> 10;
  endfunction

  function automatic ekf_pkg::s_mat_t rand_s_mat();
    ekf_pkg::s_mat_t s;
    s.s11 = rand_fx() & 32'h001f_ffff;  // positive diagonal
    s.s21 = rand_fx() >>> 3;            // below 0.5, det stays near the diagonal product
    s.s22 = rand_fx() & 32'h001f_ffff;
    return s;
  endfunction

  task automatic drive_jacobians();
    ekf_pkg::pred_jac_t p;
    ekf_pkg::new_lm_t   g;
    ekf_pkg::upd_jac_t  h;
    for (int i = 0; i < $bits(p) / 32; i++)
      p[i*32 +: 32] = rand_fx();
    for (int i = 0; i < $bits(g) / 32; i++)
      g[i*32 +: 32] = rand_fx();
    for (int i = 0; i < $bits(h) / 32; i++)
      h[i*32 +: 32] = rand_fx();
    @(posedge clk);
    pred_jac <= p;
    new_lm   <= g;
    upd_jac  <= h;
  endtask

  task automatic run_vectors(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      @(posedge clk);
      bca_sel <= VEC_TAB[i].sel;
      seq_cnt <= VEC_TAB[i].seq;
      @(posedge clk);
      @(negedge clk);
      check_row(b_cache_din, exp_rows[VEC_TAB[i].idx],
                $sformatf("sel %b seq %0d", VEC_TAB[i].sel, VEC_TAB[i].seq));
    end
  endtask

  task automatic pulse_start(input ekf_pkg::s_mat_t s);
    @(posedge clk);
    s_mat     <= s;
    inv_start <= 1'b1;
    @(posedge clk);
    inv_start <= 1'b0;
  endtask

  task automatic wait_inv_done(input int min_cycles);
    int n;
    n = 0;
    while (inv_done !== 1'b1) begin
      if (n >= DONE_LIMIT) begin
        report_fail($sformatf("inverse never finished within %0d cycles", DONE_LIMIT));
      end else begin
        @(negedge clk);
        n++;
      end
    end
    if (n < min_cycles)
      report_fail($sformatf("inverse finished after %0d cycles, at least %0d expected",
                            n, min_cycles));
  endtask

  task automatic check_inverse(input ekf_pkg::s_mat_t s, input string what);
    inv_exp = ref_inv(s);
    check_inv(DUT.s_inv, inv_exp, what);
    build_rows();
    run_vectors(VEC_INV_FIRST, N_VEC - 1);
  endtask

  initial begin
    seed      = 32'h208d;
    sys_rst   = 1'b1;
    bca_sel   = ekf_pkg::IDLE;
    seq_cnt   = '0;
    pred_jac  = '0;
    new_lm    = '0;
    upd_jac   = '0;
    s_mat     = '0;
    inv_start = 1'b0;
    inv_exp   = '0;
    repeat (2) @(posedge clk);
    sys_rst <= 1'b0;

    // quiet output with no start
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_row(b_cache_din, '0, "after reset");
      check_flag(inv_done, 1'b0, "inv_done with no start");
    end

    repeat (2) begin
      drive_jacobians();
      @(negedge clk);
      build_rows();
      run_vectors(0, VEC_MAP_LAST);
    end

    s_a = rand_s_mat();
    s_b = rand_s_mat();
    s_c = rand_s_mat();
    pulse_start(s_a);
    wait_inv_done(3 * DIV_ITER);
    check_inverse(s_a, "first inverse");

    // second start lands while the core is busy
    pulse_start(s_b);
    repeat (6) @(posedge clk);
    pulse_start(s_c);
    wait_inv_done(3 * DIV_ITER - 8);  // run on s_b began 8 cycles earlier
    check_inverse(s_b, "start while busy");

    pulse_start(s_c);
    wait_inv_done(3 * DIV_ITER);
    check_inverse(s_c, "restart after done");

    $display("Regression passed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+verification
common/ekf_pkg.sv
s_inv/fx_div.sv
s_inv/s_inv_core.sv
hdl/bcache_din_map.sv
hdl/bcache_din_top.sv
verification/tb_bcache_din.sv

// File: Makefile
TOP := tb_bcache_din

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f vlog.f --top-module $(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Regression failed" sim.log; then \
	  echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "Regression passed" sim.log; then \
	  echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
